// ==== source/core_pkg.sv ====
package core_pkg;

	// Datapath and register file sizes
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int FETCH_W    = 64;

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// Kept instruction classes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct7 that turns ADD into SUB
	localparam logic [6:0] F7_SUB = 7'b0100000;

	localparam int ALU_OP_W = 3;

	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT    = 3'd5;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd6;

	typedef struct packed {
		logic [6:0]            funct7;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [REG_ADDR_W-1:0] rd;
		logic [6:0]            opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]           imm;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [REG_ADDR_W-1:0] rd;
		logic [6:0]            opcode;
	} i_fmt_t;

	// One instruction word, seen as register or immediate form
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	typedef struct packed {
		logic                  wr_en;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic                  use_rs2;
		logic [ALU_OP_W-1:0]   alu_op;
		logic [XLEN-1:0]       imm;
	} lane_ctrl_t;

	typedef struct packed {
		lane_ctrl_t      ctrl;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
	} exec_req_t;

	typedef struct packed {
		logic                  en;
		logic [REG_ADDR_W-1:0] addr;
		logic [XLEN-1:0]       data;
	} wb_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
	input  logic                          clk,
	input  logic                          i_rst,
	input  logic                          i_hold,
	output logic [core_pkg::XLEN-1:0]     o_fetch_pc,
	input  logic [core_pkg::FETCH_W-1:0]  i_fetch_instr,
	output core_pkg::instr_u              o_instr_0,
	output core_pkg::instr_u              o_instr_1
);

	logic [core_pkg::XLEN-1:0] pc;
	core_pkg::instr_u          if_id_0;
	core_pkg::instr_u          if_id_1;

	// One aligned pair per cycle
	always_ff @(posedge clk) begin
		if (i_rst) begin
			pc <= core_pkg::RESET_PC;
		end else if (!i_hold) begin
			pc <= pc + core_pkg::XLEN'(core_pkg::FETCH_W / 8);
		end
	end

	// Zero word has an unknown opcode and decodes as a no-operation
	always_ff @(posedge clk) begin
		if (i_rst) begin
			if_id_0 <= '0;
			if_id_1 <= '0;
		end else if (!i_hold) begin
			if_id_0 <= i_fetch_instr[core_pkg::XLEN-1:0];
			if_id_1 <= i_fetch_instr[core_pkg::FETCH_W-1:core_pkg::XLEN];
		end
	end

	assign o_fetch_pc = pc;
	assign o_instr_0  = if_id_0;
	assign o_instr_1  = if_id_1;

endmodule

// ==== source/lane_decoder.sv ====
`timescale 1ns/100ps

module lane_decoder (
	input  core_pkg::instr_u     i_instr,
	output core_pkg::lane_ctrl_t o_ctrl
);

	logic known;
	logic f7_base;
	logic f7_sub;

	assign f7_base = (i_instr.r_fmt.funct7 == '0);
	assign f7_sub  = (i_instr.r_fmt.funct7 == core_pkg::F7_SUB);

	always_comb begin
		o_ctrl = '0;
		known  = 1'b0;
		case (i_instr.r_fmt.opcode)
			core_pkg::OPC_OP: begin
				o_ctrl.rd      = i_instr.r_fmt.rd;
				o_ctrl.rs1     = i_instr.r_fmt.rs1;
				o_ctrl.rs2     = i_instr.r_fmt.rs2;
				o_ctrl.use_rs2 = 1'b1;
				case (i_instr.r_fmt.funct3)
					core_pkg::F3_ADD: begin
						o_ctrl.alu_op = f7_sub ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
						known         = f7_base || f7_sub;
					end
					core_pkg::F3_SLT: begin
						o_ctrl.alu_op = core_pkg::ALU_SLT;
						known         = f7_base;
					end
					core_pkg::F3_XOR: begin
						o_ctrl.alu_op = core_pkg::ALU_XOR;
						known         = f7_base;
					end
					core_pkg::F3_OR: begin
						o_ctrl.alu_op = core_pkg::ALU_OR;
						known         = f7_base;
					end
					core_pkg::F3_AND: begin
						o_ctrl.alu_op = core_pkg::ALU_AND;
						known         = f7_base;
					end
					default: known = 1'b0;
				endcase
			end
			core_pkg::OPC_OP_IMM: begin
				o_ctrl.rd  = i_instr.i_fmt.rd;
				o_ctrl.rs1 = i_instr.i_fmt.rs1;
				o_ctrl.imm = {{(core_pkg::XLEN-12){i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
				known      = 1'b1;
				case (i_instr.i_fmt.funct3)
					core_pkg::F3_ADD: o_ctrl.alu_op = core_pkg::ALU_ADD;
					core_pkg::F3_XOR: o_ctrl.alu_op = core_pkg::ALU_XOR;
					core_pkg::F3_OR:  o_ctrl.alu_op = core_pkg::ALU_OR;
					core_pkg::F3_AND: o_ctrl.alu_op = core_pkg::ALU_AND;
					// No SLTI in the kept subset
					default:          known = 1'b0;
				endcase
			end
			core_pkg::OPC_LUI: begin
				// Upper immediate spans the imm, rs1 and funct3 fields
				o_ctrl.rd     = i_instr.i_fmt.rd;
				o_ctrl.imm    = {i_instr.i_fmt.imm, i_instr.i_fmt.rs1,
					i_instr.i_fmt.funct3, 12'b0};
				o_ctrl.alu_op = core_pkg::ALU_PASS_B;
				known         = 1'b1;
			end
			default: known = 1'b0;
		endcase

		// Unknown words must not look like readers either
		if (!known) begin
			o_ctrl = '0;
		end
		o_ctrl.wr_en = known && (o_ctrl.rd != '0);
	end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
	input  logic                             clk,
	input  logic                             i_rst,
	input  logic [core_pkg::REG_ADDR_W-1:0]  i_rs1_0,
	input  logic [core_pkg::REG_ADDR_W-1:0]  i_rs2_0,
	input  logic [core_pkg::REG_ADDR_W-1:0]  i_rs1_1,
	input  logic [core_pkg::REG_ADDR_W-1:0]  i_rs2_1,
	output logic [core_pkg::XLEN-1:0]        o_rd1_0,
	output logic [core_pkg::XLEN-1:0]        o_rd2_0,
	output logic [core_pkg::XLEN-1:0]        o_rd1_1,
	output logic [core_pkg::XLEN-1:0]        o_rd2_1,
	input  core_pkg::wb_t                    i_wb_0,
	input  core_pkg::wb_t                    i_wb_1
);

	logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

	// Lane 1 is written last so it wins on a shared address
	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (i_wb_0.en && (i_wb_0.addr != '0)) begin
				regs[i_wb_0.addr] <= i_wb_0.data;
			end
			if (i_wb_1.en && (i_wb_1.addr != '0)) begin
				regs[i_wb_1.addr] <= i_wb_1.data;
			end
		end
	end

	// x0 is hardwired
	assign o_rd1_0 = (i_rs1_0 == '0) ? '0 : regs[i_rs1_0];
	assign o_rd2_0 = (i_rs2_0 == '0) ? '0 : regs[i_rs2_0];
	assign o_rd1_1 = (i_rs1_1 == '0) ? '0 : regs[i_rs1_1];
	assign o_rd2_1 = (i_rs2_1 == '0) ? '0 : regs[i_rs2_1];

endmodule

// ==== source/issue_unit.sv ====
`timescale 1ns/100ps

module issue_unit (
	input  logic                 clk,
	input  logic                 i_rst,
	input  core_pkg::lane_ctrl_t i_ctrl_0,
	input  core_pkg::lane_ctrl_t i_ctrl_1,
	output core_pkg::lane_ctrl_t o_issue_0,
	output core_pkg::lane_ctrl_t o_issue_1,
	output logic                 o_hold
);

	logic dep;
	logic rs1_hit;
	logic rs2_hit;
	// High during the second cycle of a split pair
	logic split_b;

	assign rs1_hit = (i_ctrl_1.rs1 == i_ctrl_0.rd);
	assign rs2_hit = i_ctrl_1.use_rs2 && (i_ctrl_1.rs2 == i_ctrl_0.rd);

	// Lane 1 needs a result lane 0 has not produced yet
	assign dep = i_ctrl_0.wr_en && (i_ctrl_0.rd != '0) && (rs1_hit || rs2_hit);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			split_b <= 1'b0;
		end else begin
			split_b <= dep && !split_b;
		end
	end

	always_comb begin
		o_issue_0 = i_ctrl_0;
		o_issue_1 = i_ctrl_1;
		o_hold    = 1'b0;
		if (split_b) begin
			// Lane 0 already went last cycle
			o_issue_0.wr_en = 1'b0;
		end else if (dep) begin
			// Lane 0 alone, keep the pair in IF/ID for one more cycle
			o_issue_1.wr_en = 1'b0;
			o_hold          = 1'b1;
		end
	end

endmodule

// ==== source/bypass_net.sv ====
`timescale 1ns/100ps

module bypass_net (
	input  core_pkg::lane_ctrl_t                 i_issue_0,
	input  core_pkg::lane_ctrl_t                 i_issue_1,
	// Index 0 holds rs1 and index 1 holds rs2
	input  logic [1:0][core_pkg::XLEN-1:0]       i_rf_0,
	input  logic [1:0][core_pkg::XLEN-1:0]       i_rf_1,
	input  core_pkg::wb_t                        i_ex_0,
	input  core_pkg::wb_t                        i_ex_1,
	input  core_pkg::wb_t                        i_wbk_0,
	input  core_pkg::wb_t                        i_wbk_1,
	output core_pkg::exec_req_t                  o_req_0,
	output core_pkg::exec_req_t                  o_req_1
);

	logic [core_pkg::XLEN-1:0] rs2_val_0;
	logic [core_pkg::XLEN-1:0] rs2_val_1;

	// Newest producer first
	function automatic logic [core_pkg::XLEN-1:0] resolve(
		input logic [core_pkg::REG_ADDR_W-1:0] addr,
		input logic [core_pkg::XLEN-1:0]       rf_val,
		input core_pkg::wb_t                   ex_1,
		input core_pkg::wb_t                   ex_0,
		input core_pkg::wb_t                   wbk_1,
		input core_pkg::wb_t                   wbk_0
	);
		if (addr == '0)
			return '0;
		if (ex_1.en && (ex_1.addr == addr))
			return ex_1.data;
		if (ex_0.en && (ex_0.addr == addr))
			return ex_0.data;
		if (wbk_1.en && (wbk_1.addr == addr))
			return wbk_1.data;
		if (wbk_0.en && (wbk_0.addr == addr))
			return wbk_0.data;
		return rf_val;
	endfunction

	assign rs2_val_0 = resolve(i_issue_0.rs2, i_rf_0[1], i_ex_1, i_ex_0, i_wbk_1, i_wbk_0);
	assign rs2_val_1 = resolve(i_issue_1.rs2, i_rf_1[1], i_ex_1, i_ex_0, i_wbk_1, i_wbk_0);

	assign o_req_0.ctrl = i_issue_0;
	assign o_req_0.op_a = resolve(i_issue_0.rs1, i_rf_0[0], i_ex_1, i_ex_0, i_wbk_1, i_wbk_0);
	assign o_req_0.op_b = i_issue_0.use_rs2 ? rs2_val_0 : i_issue_0.imm;

	assign o_req_1.ctrl = i_issue_1;
	assign o_req_1.op_a = resolve(i_issue_1.rs1, i_rf_1[0], i_ex_1, i_ex_0, i_wbk_1, i_wbk_0);
	assign o_req_1.op_b = i_issue_1.use_rs2 ? rs2_val_1 : i_issue_1.imm;

endmodule

// ==== source/exec_lane.sv ====
`timescale 1ns/100ps

module exec_lane (
	input  logic                clk,
	input  logic                i_rst,
	input  core_pkg::exec_req_t i_req,
	output core_pkg::wb_t       o_ex,
	output core_pkg::wb_t       o_wb
);

	core_pkg::exec_req_t       id_ex;
	core_pkg::wb_t             ex_wb;
	logic [core_pkg::XLEN-1:0] alu_res;
	logic [core_pkg::XLEN-1:0] a;
	logic [core_pkg::XLEN-1:0] b;

	// ID/EX
	always_ff @(posedge clk) begin
		if (i_rst) begin
			id_ex.ctrl.wr_en <= 1'b0;
		end else begin
			id_ex <= i_req;
		end
	end

	assign a = id_ex.op_a;
	assign b = id_ex.op_b;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			core_pkg::ALU_ADD:    alu_res = a + b;
			core_pkg::ALU_SUB:    alu_res = a - b;
			core_pkg::ALU_AND:    alu_res = a & b;
			core_pkg::ALU_OR:     alu_res = a | b;
			core_pkg::ALU_XOR:    alu_res = a ^ b;
			core_pkg::ALU_SLT:    alu_res = core_pkg::XLEN'($signed(a) < $signed(b));
			core_pkg::ALU_PASS_B: alu_res = b;
			default:              alu_res = '0;
		endcase
	end

	// Result of the instruction now in EX, for forwarding
	assign o_ex.en   = id_ex.ctrl.wr_en;
	assign o_ex.addr = id_ex.ctrl.rd;
	assign o_ex.data = alu_res;

	// EX/WB
	always_ff @(posedge clk) begin
		if (i_rst) begin
			ex_wb.en <= 1'b0;
		end else begin
			ex_wb <= o_ex;
		end
	end

	assign o_wb = ex_wb;

endmodule

// ==== source/dual_issue_core.sv ====
`timescale 1ns/100ps

module dual_issue_core (
	input  logic                          clk,
	input  logic                          i_rst,
	output logic [core_pkg::XLEN-1:0]     o_fetch_pc,
	input  logic [core_pkg::FETCH_W-1:0]  i_fetch_instr,
	output core_pkg::wb_t                 o_wb_0,
	output core_pkg::wb_t                 o_wb_1
);

	logic                      hold;
	core_pkg::instr_u          instr_0;
	core_pkg::instr_u          instr_1;
	core_pkg::lane_ctrl_t      dec_0;
	core_pkg::lane_ctrl_t      dec_1;
	core_pkg::lane_ctrl_t      issue_0;
	core_pkg::lane_ctrl_t      issue_1;
	logic [core_pkg::XLEN-1:0] rf_rd1_0;
	logic [core_pkg::XLEN-1:0] rf_rd2_0;
	logic [core_pkg::XLEN-1:0] rf_rd1_1;
	logic [core_pkg::XLEN-1:0] rf_rd2_1;
	core_pkg::exec_req_t       req_0;
	core_pkg::exec_req_t       req_1;
	core_pkg::wb_t             ex_0;
	core_pkg::wb_t             ex_1;

	fetch_unit u_fetch (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_hold        (hold),
		.o_fetch_pc    (o_fetch_pc),
		.i_fetch_instr (i_fetch_instr),
		.o_instr_0     (instr_0),
		.o_instr_1     (instr_1)
	);

	lane_decoder u_dec_0 (.i_instr(instr_0), .o_ctrl(dec_0));
	lane_decoder u_dec_1 (.i_instr(instr_1), .o_ctrl(dec_1));

	issue_unit u_issue (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_ctrl_0  (dec_0),
		.i_ctrl_1  (dec_1),
		.o_issue_0 (issue_0),
		.o_issue_1 (issue_1),
		.o_hold    (hold)
	);

	reg_file u_rf (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_rs1_0 (issue_0.rs1),
		.i_rs2_0 (issue_0.rs2),
		.i_rs1_1 (issue_1.rs1),
		.i_rs2_1 (issue_1.rs2),
		.o_rd1_0 (rf_rd1_0),
		.o_rd2_0 (rf_rd2_0),
		.o_rd1_1 (rf_rd1_1),
		.o_rd2_1 (rf_rd2_1),
		.i_wb_0  (o_wb_0),
		.i_wb_1  (o_wb_1)
	);

	bypass_net u_bypass (
		.i_issue_0 (issue_0),
		.i_issue_1 (issue_1),
		.i_rf_0    ({rf_rd2_0, rf_rd1_0}),
		.i_rf_1    ({rf_rd2_1, rf_rd1_1}),
		.i_ex_0    (ex_0),
		.i_ex_1    (ex_1),
		.i_wbk_0   (o_wb_0),
		.i_wbk_1   (o_wb_1),
		.o_req_0   (req_0),
		.o_req_1   (req_1)
	);

	exec_lane u_exec_0 (
		.clk   (clk),
		.i_rst (i_rst),
		.i_req (req_0),
		.o_ex  (ex_0),
		.o_wb  (o_wb_0)
	);

	exec_lane u_exec_1 (
		.clk   (clk),
		.i_rst (i_rst),
		.i_req (req_1),
		.o_ex  (ex_1),
		.o_wb  (o_wb_1)
	);

endmodule

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// In-order model of the kept subset, one instruction after the other
logic [31:0] model_regs [32];
logic [4:0]  exp_addr [$];
logic [31:0] exp_data [$];

function automatic logic instr_known(input logic [31:0] w);
	logic [2:0] f3;
	logic [6:0] f7;
	logic       ok;
	f3 = w[14:12];
	f7 = w[31:25];
	case (w[6:0])
		core_pkg::OPC_LUI:    ok = 1'b1;
		core_pkg::OPC_OP_IMM: ok = (f3 == core_pkg::F3_ADD) || (f3 == core_pkg::F3_XOR) ||
			(f3 == core_pkg::F3_OR) || (f3 == core_pkg::F3_AND);
		core_pkg::OPC_OP: begin
			if (f7 == 7'b0100000) begin
				ok = (f3 == core_pkg::F3_ADD);
			end else begin
				ok = (f7 == 7'b0) && ((f3 == core_pkg::F3_ADD) || (f3 == core_pkg::F3_SLT) ||
					(f3 == core_pkg::F3_XOR) || (f3 == core_pkg::F3_OR) ||
					(f3 == core_pkg::F3_AND));
			end
		end
		default:              ok = 1'b0;
	endcase
	return ok;
endfunction

function automatic logic instr_writes(input logic [31:0] w);
	return instr_known(w) && (w[11:7] != 5'd0);
endfunction

// Lane 1 of a pair waits when it reads what lane 0 writes
function automatic logic pair_splits(input logic [31:0] w0, input logic [31:0] w1);
	logic rd1_hit;
	logic rd2_hit;
	rd1_hit = instr_known(w1) && (w1[6:0] != core_pkg::OPC_LUI) && (w1[19:15] == w0[11:7]);
	rd2_hit = instr_known(w1) && (w1[6:0] == core_pkg::OPC_OP) && (w1[24:20] == w0[11:7]);
	return instr_writes(w0) && (rd1_hit || rd2_hit);
endfunction

function automatic logic [31:0] model_result(input logic [31:0] w);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	a = model_regs[w[19:15]];
	// Register form takes rs2, immediate form the sign-extended field
	b = (w[6:0] == core_pkg::OPC_OP) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
	case (w[14:12])
		core_pkg::F3_ADD: res = (w[6:0] == core_pkg::OPC_OP && w[30]) ? a - b : a + b;
		core_pkg::F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		core_pkg::F3_XOR: res = a ^ b;
		core_pkg::F3_OR:  res = a | b;
		default:          res = a & b;
	endcase
	if (w[6:0] == core_pkg::OPC_LUI) begin
		res = {w[31:12], 12'b0};
	end
	return res;
endfunction

task automatic build_expected(input int min_writes);
	int          n;
	logic [31:0] w;
	logic [31:0] val;
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
	n = 0;
	while ((exp_addr.size() < min_writes) && (n < MEM_WORDS * 64)) begin
		w = imem[n % MEM_WORDS];
		if (instr_writes(w)) begin
			val = model_result(w);
			model_regs[w[11:7]] = val;
			exp_addr.push_back(w[11:7]);
			exp_data.push_back(val);
		end
		n++;
	end
endtask

`endif

// ==== tests/tb_dual_issue_core.sv ====
`timescale 1ns/100ps

module tb_dual_issue_core;

	localparam int MEM_WORDS  = 256;
	localparam int NUM_CHECKS = 600;
	localparam int MAX_CYCLES = 4000;

	logic                         clk;
	logic                         i_rst;
	logic [core_pkg::XLEN-1:0]    o_fetch_pc;
	logic [core_pkg::FETCH_W-1:0] i_fetch_instr;
	core_pkg::wb_t                o_wb_0;
	core_pkg::wb_t                o_wb_1;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] lcg_state;
	int          checked;
	int          split_count;

	// Expected fetch state stepped once per cycle
	logic [31:0] exp_pc;
	logic [31:0] id_word_0;
	logic [31:0] id_word_1;
	logic        in_split_b;

	`include "tb_ref_model.svh"

	dual_issue_core uut (
		.clk           (clk),
		.i_rst         (i_rst),
		.o_fetch_pc    (o_fetch_pc),
		.i_fetch_instr (i_fetch_instr),
		.o_wb_0        (o_wb_0),
		.o_wb_1        (o_wb_1)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Same-cycle instruction port with the PC wrapping modulo the memory
	assign i_fetch_instr = {imem[{o_fetch_pc[9:3], 1'b1}], imem[{o_fetch_pc[9:3], 1'b0}]};

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] random_instr();
		logic [3:0]  sel;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic [31:0] w;
		sel = 4'(next_random() >> 28);
		// Registers x0..x7 only so that pairs often depend on each other
		rd  = {2'b00, 3'(next_random() >> 29)};
		rs1 = {2'b00, 3'(next_random() >> 29)};
		rs2 = {2'b00, 3'(next_random() >> 29)};
		imm = next_random();
		case (sel)
			4'd0:  w = {7'b0, rs2, rs1, core_pkg::F3_ADD, rd, core_pkg::OPC_OP};
			4'd1:  w = {7'b0100000, rs2, rs1, core_pkg::F3_ADD, rd, core_pkg::OPC_OP};
			4'd2:  w = {7'b0, rs2, rs1, core_pkg::F3_SLT, rd, core_pkg::OPC_OP};
			4'd3:  w = {7'b0, rs2, rs1, core_pkg::F3_XOR, rd, core_pkg::OPC_OP};
			4'd4:  w = {7'b0, rs2, rs1, core_pkg::F3_OR, rd, core_pkg::OPC_OP};
			4'd5:  w = {7'b0, rs2, rs1, core_pkg::F3_AND, rd, core_pkg::OPC_OP};
			4'd7:  w = {imm[31:20], rs1, core_pkg::F3_XOR, rd, core_pkg::OPC_OP_IMM};
			4'd8:  w = {imm[31:20], rs1, core_pkg::F3_OR, rd, core_pkg::OPC_OP_IMM};
			4'd9:  w = {imm[31:20], rs1, core_pkg::F3_AND, rd, core_pkg::OPC_OP_IMM};
			4'd10, 4'd11: w = {imm[31:12], rd, core_pkg::OPC_LUI};
			// Branch opcode and a multiply encoding lie outside the subset
			4'd14: w = {imm[31:7], 7'b1100011};
			4'd15: w = {7'b0000001, rs2, rs1, core_pkg::F3_ADD, rd, core_pkg::OPC_OP};
			default: w = {imm[31:20], rs1, core_pkg::F3_ADD, rd, core_pkg::OPC_OP_IMM};
		endcase
		return w;
	endfunction

	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = random_instr();
		end
	endtask

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_error($sformatf("mismatch at %0t: %s is 0x%08h, expected 0x%08h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_lane_write(input string name, input core_pkg::wb_t wb);
		logic [31:0] e_addr;
		logic [31:0] e_data;
		if (wb.en && (wb.addr == 5'd0)) begin
			stop_with_error({"write enable raised for register zero on ", name});
		end else if (wb.en && (exp_addr.size() == 0)) begin
			stop_with_error({"write on ", name, " with no expected write left"});
		end else if (wb.en) begin
			e_addr = exp_addr.pop_front();
			e_data = exp_data.pop_front();
			check_value({name, ".addr"}, wb.addr, e_addr);
			check_value({name, ".data"}, wb.data, e_data);
			checked++;
		end
	endtask

	// PC holds for one extra cycle only in the first cycle of a split pair
	task automatic advance_fetch_model();
		if (!in_split_b && pair_splits(id_word_0, id_word_1)) begin
			in_split_b = 1'b1;
			split_count++;
		end else begin
			in_split_b = 1'b0;
			id_word_0  = imem[{exp_pc[9:3], 1'b0}];
			id_word_1  = imem[{exp_pc[9:3], 1'b1}];
			exp_pc     = exp_pc + 32'd8;
		end
	endtask

	initial begin
		int cycles;
		i_rst       = 1'b1;
		checked     = 0;
		split_count = 0;
		lcg_state   = 32'd73;
		fill_memory();
		build_expected(NUM_CHECKS + 8);

		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			if (i == 7) begin
				i_rst <= 1'b0;
			end
			@(negedge clk);
			check_value("o_wb_0.en", o_wb_0.en, 1'b0);
			check_value("o_wb_1.en", o_wb_1.en, 1'b0);
			check_value("o_fetch_pc", o_fetch_pc, core_pkg::RESET_PC);
		end

		// IF/ID starts with two no-operations
		exp_pc     = core_pkg::RESET_PC;
		id_word_0  = '0;
		id_word_1  = '0;
		in_split_b = 1'b0;
		cycles     = 0;
		while ((checked < NUM_CHECKS) && (cycles < MAX_CYCLES)) begin
			check_value("o_fetch_pc", o_fetch_pc, exp_pc);
			check_lane_write("o_wb_0", o_wb_0);
			check_lane_write("o_wb_1", o_wb_1);
			advance_fetch_model();
			cycles++;
			@(negedge clk);
		end

		if (checked < NUM_CHECKS) begin
			stop_with_error($sformatf("timeout: only %0d of %0d writes arrived in %0d cycles",
				checked, NUM_CHECKS, cycles));
		end else begin
			$display("%0d writes checked, %0d split pairs", checked, split_count);
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// ==== files.f ====
+incdir+tests
source/core_pkg.sv
source/fetch_unit.sv
source/lane_decoder.sv
source/reg_file.sv
source/issue_unit.sv
source/bypass_net.sv
source/exec_lane.sv
source/dual_issue_core.sv
tests/tb_dual_issue_core.sv
